//--- bench/mera_bus_tb.sv
module mera_bus_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// run length and limits
	localparam int num_issue = 2000;
	localparam int timeout_cycles = num_issue * 20;
	localparam int drain_cycles = 2000;
	localparam int num_tags = 1 << mera_bus_pkg::tag_width;
	localparam int num_nb = 1 << mera_bus_pkg::nb_width;
	// stretch of the run with rep_ready held low
	localparam int hold_lo = 600;
	localparam int hold_hi = 800;

	logic clk_sys;
	logic rst;
	mera_bus_pkg::bus_req_t req;
	logic req_valid;
	logic req_ready;
	mera_bus_pkg::bus_rep_t rep;
	logic rep_valid;
	logic rep_ready;

	logic [31:0] rng_state;
	int cycle_cnt = 0;
	int loop_cnt;
	int wait_cnt;
	int issued;
	int outstanding;
	logic acc_last;

	// reference model keyed by module * words + word
	logic [mera_bus_pkg::word_width-1:0] mem_model [int];
	// expected reply per tag
	mera_bus_pkg::bus_rep_t exp_rep [num_tags];
	logic exp_dt_known [num_tags];
	logic tag_busy [num_tags];
	int exp_nb [num_tags];
	int exp_seq [num_tags];
	// per nb accept and reply counts for ordering
	int nb_acc [num_nb];
	int nb_done [num_nb];
	int free_tags [$];
	mera_bus_pkg::bus_req_t directed_q [$];

	// reply waiting under rep_ready low
	logic hold_pending;
	mera_bus_pkg::bus_rep_t held_rep;

	mera_bus i_mera_bus (
		.clk_sys(clk_sys),
		.rst(rst),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.rep(rep),
		.rep_valid(rep_valid),
		.rep_ready(rep_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// --------------------
	// helpers
	// --------------------

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic mera_bus_pkg::bus_req_t make_req(mera_bus_pkg::bus_op_e op,
		logic [mera_bus_pkg::nb_width-1:0] nb, logic [15:0] ad, logic [15:0] dt);
		mera_bus_pkg::bus_req_t r;
		r.op = op;
		r.nb = nb;
		r.ad = ad;
		r.dt = dt;
		r.tag = '0;
		return r;
	endfunction

	// nb 0..5 over eight words with random alias bits on top
	function automatic mera_bus_pkg::bus_req_t random_req();
		logic [31:0] r;
		logic [31:0] d;
		logic [9:0] word;
		int nb_i;
		mera_bus_pkg::bus_op_e op;
		r = next_rand();
		d = next_rand();
		case (r[1:0])
			2'd0: op = mera_bus_pkg::op_write;
			2'd2: op = mera_bus_pkg::op_sem;
			default: op = mera_bus_pkg::op_read;
		endcase
		nb_i = int'(r[10:8]) % 6;
		word = 10'(int'(r[13:11]) * 37);
		return make_req(op, mera_bus_pkg::nb_width'(nb_i), {r[19:14], word}, d[15:0]);
	endfunction

	task automatic fail_value(string msg);
		$display("error at %0d ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "mismatch");
	endtask

	task automatic fail_plain(string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "protocol failure");
	endtask

	task automatic compare_bit(logic got, logic exp, string what);
		if (got !== exp) begin
			fail_value($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic compare_kind(mera_bus_pkg::reply_e got, mera_bus_pkg::reply_e exp,
		string what);
		if (got !== exp) begin
			fail_value($sformatf("%s: got kind %0d, expected kind %0d",
				what, got, exp));
		end
	endtask

	task automatic compare_rep(mera_bus_pkg::bus_rep_t got, mera_bus_pkg::bus_rep_t exp,
		string what);
		if (got !== exp) begin
			fail_value($sformatf(
				"%s: got kind %0d dt %h tag %0d, expected kind %0d dt %h tag %0d",
				what, got.kind, got.dt, got.tag, exp.kind, exp.dt, exp.tag));
		end
	endtask

	task automatic compare_seq(int got, int exp, string what);
		if (got != exp) begin
			fail_value($sformatf("%s: reply of request %0d came, expected %0d",
				what, got, exp));
		end
	endtask

	// --------------------
	// model
	// --------------------

	// expected reply from the model state at acceptance
	task automatic model_accept(mera_bus_pkg::bus_req_t r);
		int key;
		int t;
		logic [15:0] old;
		mera_bus_pkg::bus_rep_t e;
		key = int'(r.nb) * mera_bus_pkg::module_words +
			int'(r.ad[mera_bus_pkg::word_sel_width-1:0]);
		t = int'(r.tag);
		e.kind = mera_bus_pkg::rep_ok;
		e.dt = '0;
		e.tag = r.tag;
		exp_dt_known[t] = 1'b0;
		if (int'(r.nb) >= mera_bus_pkg::num_modules) begin
			// empty block leaves memory untouched
			e.kind = mera_bus_pkg::rep_nomem;
		end else if (r.op == mera_bus_pkg::op_write) begin
			mem_model[key] = r.dt;
		end else begin
			e.kind = mera_bus_pkg::rep_en;
			// unwritten word stays unknown so only the kind counts
			if (mem_model.exists(key)) begin
				old = mem_model[key];
				e.dt = old;
				exp_dt_known[t] = 1'b1;
				if (r.op == mera_bus_pkg::op_sem) begin
					mem_model[key] = old | 16'h8000;
				end
			end
		end
		exp_rep[t] = e;
		tag_busy[t] = 1'b1;
		exp_nb[t] = int'(r.nb);
		exp_seq[t] = nb_acc[int'(r.nb)];
		nb_acc[int'(r.nb)]++;
		outstanding++;
	endtask

	task automatic check_reply(mera_bus_pkg::bus_rep_t r);
		int t;
		int nb;
		t = int'(r.tag);
		if (!tag_busy[t]) begin
			fail_plain($sformatf("a reply with tag %0d came with no request outstanding", t));
		end
		nb = exp_nb[t];
		// same nb answers in accept order
		compare_seq(exp_seq[t], nb_done[nb], $sformatf("order on nb %0d", nb));
		if (exp_dt_known[t]) begin
			compare_rep(r, exp_rep[t], "reply");
		end else begin
			compare_kind(r.kind, exp_rep[t].kind, "reply kind");
		end
		nb_done[nb]++;
		tag_busy[t] = 1'b0;
		free_tags.push_back(t);
		outstanding--;
	endtask

	// --------------------
	// per cycle drive and sample
	// --------------------

	task automatic drive_inputs(int cyc);
		mera_bus_pkg::bus_req_t nr;
		logic [31:0] r;
		r = next_rand();
		if (cyc >= hold_lo && cyc < hold_hi) begin
			rep_ready <= 1'b0;
		end else begin
			rep_ready <= r[1:0] != 2'd0;
		end
		// a waiting cycle stays put until accepted
		if (!req_valid || acc_last) begin
			if (issued < num_issue && free_tags.size() > 0 && r[5:4] != 2'd0) begin
				if (issued < directed_q.size()) begin
					nr = directed_q[issued];
				end else begin
					nr = random_req();
				end
				nr.tag = mera_bus_pkg::tag_width'(free_tags.pop_front());
				req <= nr;
				req_valid <= 1'b1;
				issued++;
			end else begin
				req_valid <= 1'b0;
			end
		end
	endtask

	// handshake signals are settled at the falling edge
	task automatic sample_outputs();
		if (hold_pending) begin
			compare_bit(rep_valid, 1'b1, "rep_valid while waiting");
			compare_rep(rep, held_rep, "rep while waiting");
		end
		hold_pending = rep_valid && !rep_ready;
		held_rep = rep;
		if (rep_valid && rep_ready) begin
			check_reply(rep);
		end
		acc_last = req_valid && req_ready;
		if (acc_last) begin
			model_accept(req);
		end
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial begin
		rst = 1'b1;
		req = '0;
		req_valid = 1'b0;
		rep_ready = 1'b0;
		rng_state = 32'd90497;
		issued = 0;
		outstanding = 0;
		acc_last = 1'b0;
		hold_pending = 1'b0;
		held_rep = '0;
		for (int t = 0; t < num_tags; t++) begin
			tag_busy[t] = 1'b0;
			exp_dt_known[t] = 1'b0;
			free_tags.push_back(t);
		end
		for (int n = 0; n < num_nb; n++) begin
			nb_acc[n] = 0;
			nb_done[n] = 0;
		end
		// write, aliased read, semaphore, read back, nomem, read again
		directed_q.push_back(make_req(mera_bus_pkg::op_write, 4'd0, 16'h0013, 16'h1234));
		directed_q.push_back(make_req(mera_bus_pkg::op_read, 4'd0, 16'h0413, 16'h0000));
		directed_q.push_back(make_req(mera_bus_pkg::op_sem, 4'd0, 16'h0013, 16'h0000));
		directed_q.push_back(make_req(mera_bus_pkg::op_read, 4'd0, 16'h0013, 16'h0000));
		directed_q.push_back(make_req(mera_bus_pkg::op_write, 4'd4, 16'h0013, 16'hffff));
		directed_q.push_back(make_req(mera_bus_pkg::op_read, 4'd0, 16'h0013, 16'h0000));
		directed_q.push_back(make_req(mera_bus_pkg::op_read, 4'd5, 16'h0013, 16'h0000));
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		// idle state straight out of reset
		compare_bit(rep_valid, 1'b0, "rep_valid after reset");
		compare_bit(req_ready, 1'b1, "req_ready after reset");
		loop_cnt = 0;
		while (!(issued == num_issue && !req_valid)) begin
			@(posedge clk_sys);
			drive_inputs(loop_cnt);
			@(negedge clk_sys);
			sample_outputs();
			loop_cnt++;
		end
		// collect the last replies
		wait_cnt = 0;
		while (outstanding != 0 && wait_cnt < drain_cycles) begin
			@(posedge clk_sys);
			drive_inputs(loop_cnt);
			@(negedge clk_sys);
			sample_outputs();
			loop_cnt++;
			wait_cnt++;
		end
		if (outstanding != 0) begin
			$display("%0d accepted requests never got a reply", outstanding);
			$display("Test failed");
			$fatal(1, "missing replies");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

	// hard stop for a stuck bus
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > timeout_cycles) begin
			$display("timeout after %0d cycles with %0d replies outstanding",
				timeout_cycles, outstanding);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

endmodule

//--- logic/bus_dispatch.sv
module bus_dispatch (
	input logic clk_sys,
	input logic rst,
	// requester side
	input mera_bus_pkg::bus_req_t req,
	input logic req_valid,
	output logic req_ready,
	// toward the memory modules
	output mera_bus_pkg::bus_req_t mod_req,
	output logic [mera_bus_pkg::num_modules-1:0] mod_push,
	input logic [mera_bus_pkg::num_modules-1:0] credit_ret,
	// no memory slot
	output mera_bus_pkg::bus_rep_t nomem_rep,
	output logic nomem_full,
	input logic nomem_pop
);

	// staged bus cycle
	logic stg_valid;
	mera_bus_pkg::bus_req_t stg;

	// decode of the staged nb
	logic stg_in_range;
	logic [mera_bus_pkg::mod_sel_width-1:0] stg_idx;
	logic stg_go;
	logic accept;

	// one counter per module
	mera_bus_pkg::credit_t credit [mera_bus_pkg::num_modules];

	// --------------------
	// request stage
	// --------------------

	assign stg_in_range = stg.nb < mera_bus_pkg::nb_width'(mera_bus_pkg::num_modules);
	assign stg_idx = stg.nb[mera_bus_pkg::mod_sel_width-1:0];

	// stage empties toward a module with credit
	// or into a free nomem slot
	assign stg_go = stg_valid &&
		(stg_in_range ? (credit[stg_idx] != '0) : !nomem_full);

	// stall while a cycle waits or nomem reply is pending
	assign req_ready = (!stg_valid || stg_go) && !nomem_full;
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			stg_valid <= 1'b0;
		end else if (accept) begin
			stg_valid <= 1'b1;
		end else if (stg_go) begin
			stg_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			stg <= req;
		end
	end

	// all modules see the same cycle, push selects one
	assign mod_req = stg;

	always_comb begin
		mod_push = '0;
		if (stg_go && stg_in_range) begin
			mod_push[stg_idx] = 1'b1;
		end
	end

	// --------------------
	// credit counters
	// --------------------

	// spent on push, given back when the merger pops
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < mera_bus_pkg::num_modules; i++) begin
			if (rst) begin
				credit[i] <= mera_bus_pkg::credit_t'(mera_bus_pkg::credits_per_module);
			end else begin
				credit[i] <= credit[i] + mera_bus_pkg::credit_t'(credit_ret[i])
					- mera_bus_pkg::credit_t'(mod_push[i]);
			end
		end
	end

	for (genvar i = 0; i < mera_bus_pkg::num_modules; i++) begin : g_credit_chk
		// returns never outnumber pushes
		a_credit_max: assert property (@(posedge clk_sys) disable iff (rst)
			credit[i] <= mera_bus_pkg::credit_t'(mera_bus_pkg::credits_per_module));
		// module fifo has room for every push
		a_push_credit: assert property (@(posedge clk_sys) disable iff (rst)
			mod_push[i] |-> credit[i] != '0);
	end

	// --------------------
	// nomem slot
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			nomem_full <= 1'b0;
		end else if (stg_go && !stg_in_range) begin
			nomem_full <= 1'b1;
		end else if (nomem_pop) begin
			nomem_full <= 1'b0;
		end
	end

	// reply keeps the tag of the cycle
	always_ff @(posedge clk_sys) begin
		if (stg_go && !stg_in_range) begin
			nomem_rep <= '{kind: mera_bus_pkg::rep_nomem, dt: '0, tag: stg.tag};
		end
	end

endmodule

//--- logic/mem_module.sv
module mem_module (
	input logic clk_sys,
	input logic rst,
	input mera_bus_pkg::bus_req_t mod_req,
	input logic push,
	input logic pop,
	output mera_bus_pkg::bus_rep_t fifo_head,
	output logic fifo_nonempty
);

	logic [mera_bus_pkg::word_width-1:0] mem_array [mera_bus_pkg::module_words];

	// second pipe stage
	logic s1_valid;
	mera_bus_pkg::bus_req_t s1_req;
	logic [mera_bus_pkg::word_width-1:0] rd_raw;
	logic [mera_bus_pkg::word_width-1:0] rd_old;
	logic [mera_bus_pkg::word_width-1:0] wr_word;
	logic [mera_bus_pkg::word_width-1:0] fwd_word;
	logic fwd_hit;
	logic fwd_now;

	// reply fifo
	mera_bus_pkg::bus_rep_t fifo_q [mera_bus_pkg::credits_per_module];
	mera_bus_pkg::fifo_ptr_t wr_ptr;
	mera_bus_pkg::fifo_ptr_t rd_ptr;
	mera_bus_pkg::credit_t fifo_count;
	logic ins_a;
	logic ins_b;
	logic [1:0] ins_n;

	// --------------------
	// operation pipe
	// --------------------

	// s1 stores at the same edge the new cycle reads
	// so its word is forwarded
	assign fwd_now = s1_valid && s1_req.op != mera_bus_pkg::op_read &&
		s1_req.ad[mera_bus_pkg::word_sel_width-1:0] ==
		mod_req.ad[mera_bus_pkg::word_sel_width-1:0];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= push;
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_raw <= mem_array[mod_req.ad[mera_bus_pkg::word_sel_width-1:0]];
		if (push) begin
			s1_req <= mod_req;
			fwd_hit <= fwd_now;
			fwd_word <= wr_word;
		end
	end

	// old word of the op in s1
	assign rd_old = fwd_hit ? fwd_word : rd_raw;

	// write data, or semaphore word with msb set
	assign wr_word = (s1_req.op == mera_bus_pkg::op_write) ? s1_req.dt :
		{1'b1, rd_old[mera_bus_pkg::word_width-2:0]};

	// single store port, used by write and semaphore
	always_ff @(posedge clk_sys) begin
		if (s1_valid && s1_req.op != mera_bus_pkg::op_read) begin
			mem_array[s1_req.ad[mera_bus_pkg::word_sel_width-1:0]] <= wr_word;
		end
	end

	// --------------------
	// reply fifo
	// --------------------

	// read/sem data leaves s1, write ack leaves at push
	// both in one cycle keeps s1 ahead as the older op
	assign ins_a = s1_valid && s1_req.op != mera_bus_pkg::op_write;
	assign ins_b = push && mod_req.op == mera_bus_pkg::op_write;
	assign ins_n = {1'b0, ins_a} + {1'b0, ins_b};

	always_ff @(posedge clk_sys) begin
		if (ins_a) begin
			fifo_q[wr_ptr] <= '{kind: mera_bus_pkg::rep_en, dt: rd_old, tag: s1_req.tag};
		end
		if (ins_b) begin
			fifo_q[ins_a ? wr_ptr + 1'b1 : wr_ptr] <=
				'{kind: mera_bus_pkg::rep_ok, dt: '0, tag: mod_req.tag};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
		end else begin
			wr_ptr <= wr_ptr + mera_bus_pkg::fifo_ptr_t'(ins_n);
			rd_ptr <= rd_ptr + mera_bus_pkg::fifo_ptr_t'(pop);
			fifo_count <= fifo_count + mera_bus_pkg::credit_t'(ins_n)
				- mera_bus_pkg::credit_t'(pop);
		end
	end

	assign fifo_head = fifo_q[rd_ptr];
	assign fifo_nonempty = fifo_count != '0;

	// dispatcher credits cover every op in flight
	a_fifo_room: assert property (@(posedge clk_sys) disable iff (rst)
		(ins_a || ins_b) |-> int'(fifo_count) + int'(ins_n) <=
		mera_bus_pkg::credits_per_module);

endmodule

//--- logic/mera_bus.sv
module mera_bus (
	input logic clk_sys,
	input logic rst,
	// requester bus cycles
	input mera_bus_pkg::bus_req_t req,
	input logic req_valid,
	output logic req_ready,
	// replies
	output mera_bus_pkg::bus_rep_t rep,
	output logic rep_valid,
	input logic rep_ready
);

	// dispatcher to modules
	mera_bus_pkg::bus_req_t mod_req;
	logic [mera_bus_pkg::num_modules-1:0] mod_push;

	// modules to merger, pop doubles as credit return
	mera_bus_pkg::bus_rep_t fifo_head [mera_bus_pkg::num_modules];
	logic [mera_bus_pkg::num_modules-1:0] fifo_nonempty;
	logic [mera_bus_pkg::num_modules-1:0] pop;

	// nomem path
	mera_bus_pkg::bus_rep_t nomem_rep;
	logic nomem_full;
	logic nomem_pop;

	// --------------------
	// dispatch
	// --------------------

	bus_dispatch i_dispatch (
		.clk_sys(clk_sys),
		.rst(rst),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.mod_req(mod_req),
		.mod_push(mod_push),
		.credit_ret(pop),
		.nomem_rep(nomem_rep),
		.nomem_full(nomem_full),
		.nomem_pop(nomem_pop)
	);

	// --------------------
	// memory modules
	// --------------------

	for (genvar i = 0; i < mera_bus_pkg::num_modules; i++) begin : g_mem
		mem_module i_mem (
			.clk_sys(clk_sys),
			.rst(rst),
			.mod_req(mod_req),
			.push(mod_push[i]),
			.pop(pop[i]),
			.fifo_head(fifo_head[i]),
			.fifo_nonempty(fifo_nonempty[i])
		);
	end

	// --------------------
	// reply merge
	// --------------------

	reply_merge i_merge (
		.clk_sys(clk_sys),
		.rst(rst),
		.fifo_head(fifo_head),
		.fifo_nonempty(fifo_nonempty),
		.pop(pop),
		.nomem_rep(nomem_rep),
		.nomem_full(nomem_full),
		.nomem_pop(nomem_pop),
		.rep(rep),
		.rep_valid(rep_valid),
		.rep_ready(rep_ready)
	);

endmodule

//--- logic/mera_bus_pkg.sv
package mera_bus_pkg;

	// --------------------
	// bus sizes
	// --------------------

	// installed memory modules
	localparam int num_modules = 4;

	// words per module
	localparam int module_words = 1024;

	// reply fifo depth, also starting credit
	localparam int credits_per_module = 4;

	// field widths of one bus cycle
	localparam int nb_width = 4;
	localparam int tag_width = 4;
	localparam int word_width = 16;
	localparam int ad_width = 16;

	// low address bits that pick a word, upper bits alias
	localparam int word_sel_width = $clog2(module_words);

	// module index taken from the low nb bits
	localparam int mod_sel_width = $clog2(num_modules);

	// credit counter / fifo fill level, counts 0..depth
	localparam int cnt_width = $clog2(credits_per_module + 1);

	// fifo pointer, depth is a power of two so it wraps on its own
	localparam int ptr_width = $clog2(credits_per_module);

	// reply sources seen by the merger
	// modules first, the nomem slot last
	localparam int num_sources = num_modules + 1;
	localparam int src_width = $clog2(num_sources);

	typedef logic [cnt_width-1:0] credit_t;
	typedef logic [ptr_width-1:0] fifo_ptr_t;
	typedef logic [src_width-1:0] src_ptr_t;

	// --------------------
	// encodings
	// --------------------

	// requester operations
	typedef enum logic [1:0] {
		op_write,
		op_read,
		op_sem
	} bus_op_e;

	// reply kinds
	// ok for writes, en with data, nomem for empty blocks
	typedef enum logic [1:0] {
		rep_ok,
		rep_en,
		rep_nomem
	} reply_e;

	// --------------------
	// bus records
	// --------------------

	// one bus cycle, 42 bits
	typedef struct packed {
		bus_op_e op;
		logic [nb_width-1:0] nb;
		logic [ad_width-1:0] ad;
		logic [word_width-1:0] dt;
		logic [tag_width-1:0] tag;
	} bus_req_t;

	// one reply, 22 bits
	typedef struct packed {
		reply_e kind;
		logic [word_width-1:0] dt;
		logic [tag_width-1:0] tag;
	} bus_rep_t;

endpackage

//--- logic/reply_merge.sv
module reply_merge (
	input logic clk_sys,
	input logic rst,
	// module fifos
	input mera_bus_pkg::bus_rep_t fifo_head [mera_bus_pkg::num_modules],
	input logic [mera_bus_pkg::num_modules-1:0] fifo_nonempty,
	output logic [mera_bus_pkg::num_modules-1:0] pop,
	// nomem slot
	input mera_bus_pkg::bus_rep_t nomem_rep,
	input logic nomem_full,
	output logic nomem_pop,
	// requester side
	output mera_bus_pkg::bus_rep_t rep,
	output logic rep_valid,
	input logic rep_ready
);

	logic [mera_bus_pkg::num_sources-1:0] src_req;
	mera_bus_pkg::bus_rep_t src_rep [mera_bus_pkg::num_sources];
	mera_bus_pkg::src_ptr_t rr_ptr;
	mera_bus_pkg::src_ptr_t sel_idx;
	logic sel_found;
	logic out_free;
	logic take;

	// modules 0..3, then the nomem slot
	always_comb begin
		for (int i = 0; i < mera_bus_pkg::num_modules; i++) begin
			src_req[i] = fifo_nonempty[i];
			src_rep[i] = fifo_head[i];
		end
		src_req[mera_bus_pkg::num_modules] = nomem_full;
		src_rep[mera_bus_pkg::num_modules] = nomem_rep;
	end

	// first waiting source at or after the pointer
	always_comb begin
		int idx;
		sel_found = 1'b0;
		sel_idx = '0;
		for (int k = 0; k < mera_bus_pkg::num_sources; k++) begin
			idx = int'(rr_ptr) + k;
			if (idx >= mera_bus_pkg::num_sources) begin
				idx = idx - mera_bus_pkg::num_sources;
			end
			if (!sel_found && src_req[idx]) begin
				sel_found = 1'b1;
				sel_idx = mera_bus_pkg::src_ptr_t'(idx);
			end
		end
	end

	// output register free or draining this cycle
	assign out_free = !rep_valid || rep_ready;
	assign take = sel_found && out_free;

	always_comb begin
		for (int i = 0; i < mera_bus_pkg::num_modules; i++) begin
			pop[i] = take && sel_idx == mera_bus_pkg::src_ptr_t'(i);
		end
		nomem_pop = take &&
			sel_idx == mera_bus_pkg::src_ptr_t'(mera_bus_pkg::num_modules);
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rr_ptr <= '0;
			rep_valid <= 1'b0;
		end else if (take) begin
			rep_valid <= 1'b1;
			// skip past the source just served
			rr_ptr <= (sel_idx == mera_bus_pkg::src_ptr_t'(mera_bus_pkg::num_sources - 1)) ?
				'0 : sel_idx + 1'b1;
		end else if (rep_ready) begin
			rep_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			rep <= src_rep[sel_idx];
		end
	end

	// requester sees a held reply
	a_rep_hold: assert property (@(posedge clk_sys) disable iff (rst)
		rep_valid && !rep_ready |=> rep_valid && $stable(rep));

endmodule

//--- mera_bus.f
logic/mera_bus_pkg.sv
logic/bus_dispatch.sv
logic/mem_module.sv
logic/reply_merge.sv
logic/mera_bus.sv
bench/mera_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mera_bus testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=mera_bus_sim
log_file=sim.log

rm -rf "$build_dir"

verilator --binary --timing --assert \
	-f mera_bus.f \
	--top-module mera_bus_tb \
	-Mdir "$build_dir" \
	-o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi

grep -qx "Test passed" "$log_file"
grep_status=$?
if [ $grep_status -eq 0 ] && [ $sim_status -eq 0 ]; then
	echo "run ok, see $log_file"
	exit 0
else
	echo "run failed, see $log_file"
	exit 1
fi
